//--- common/display_pkg.sv
// ##################################################
// Display package: 640x480 raster constants, colour
// and sync types, test patterns and TMDS control codes
// ##################################################

`default_nettype none

package display_pkg;

    // Channel and coordinate widths
    localparam int bpc       = 5;   // System bits per colour channel
    localparam int bpc_board = 8;   // Encoded bits per channel
    localparam int cordw     = 16;  // Signed screen coordinate
    localparam int sym_w     = 10;  // TMDS symbol

    // 640x480 at 25.2 MHz, blanking after the active area
    localparam int h_active = 640;
    localparam int h_front  = 16;
    localparam int h_sync   = 96;
    localparam int h_back   = 48;
    localparam int h_total  = h_active + h_front + h_sync + h_back;  // 800
    localparam int v_active = 480;
    localparam int v_front  = 10;
    localparam int v_sync   = 2;
    localparam int v_back   = 33;
    localparam int v_total  = v_active + v_front + v_sync + v_back;  // 525

    localparam int frame_cycles = h_total * v_total;  // Clocks per frame
    localparam int pix_lat      = 2;                  // Counters to symbols

    // Stitch grid and colour squares share one pitch
    localparam int stitch_size  = 16;
    localparam int stitch_shift = $clog2(stitch_size);

    typedef struct packed {
        logic [bpc-1:0] r;
        logic [bpc-1:0] g;
        logic [bpc-1:0] b;
    } rgb_t;

    typedef struct packed {
        logic hsync;  // Active low
        logic vsync;  // Active low
        logic de;
    } sync_t;

    localparam sync_t sync_idle = '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};  // Blanking, no pulse

    typedef enum logic {
        pat_squares = 1'b0,  // Colour from square indices
        pat_stitch  = 1'b1   // Hitomezashi lines
    } pattern_e;

    // Bit k sets whether the dashes on stitch line k start on or off
    localparam logic [31:0] stitch_row_bits = 32'h5a3c_96e1;
    localparam logic [31:0] stitch_col_bits = 32'hc36d_2b94;

    localparam rgb_t stitch_fg = '{r: 5'h1f, g: 5'h1f, b: 5'h1f};  // White
    localparam rgb_t stitch_bg = '{r: 5'h00, g: 5'h00, b: 5'h10};  // Navy

    // TMDS control symbols, indexed by {c1, c0}
    localparam logic [sym_w-1:0] ctrl_00 = 10'b1101010100;
    localparam logic [sym_w-1:0] ctrl_01 = 10'b0010101011;
    localparam logic [sym_w-1:0] ctrl_10 = 10'b0101010100;
    localparam logic [sym_w-1:0] ctrl_11 = 10'b1010101011;

endpackage

`default_nettype wire

//--- logic/display_timing.sv
// ##################################################
// Raster timing for 640x480: screen counters, sync,
// data enable and the frame start pulse
// ##################################################

`timescale 1ns/10ps
`default_nettype none

module display_timing (
    input  wire                                  clk,
    input  wire                                  rst_n,
    output logic signed [display_pkg::cordw-1:0] sx,     // Horizontal position
    output logic signed [display_pkg::cordw-1:0] sy,     // Vertical position
    output display_pkg::sync_t                   sync,   // Aligned with sx, sy
    output logic                                 frame   // High at sx 0, sy 0
);

    import display_pkg::*;

    logic signed [cordw-1:0] sx_nxt;
    logic signed [cordw-1:0] sy_nxt;
    logic                    line_end;
    logic                    frame_end;
    sync_t                   sync_nxt;
    logic                    frame_nxt;

    // Next position, wrapping at the raster totals
    always_comb begin
        line_end  = (sx == cordw'(h_total - 1));
        frame_end = (sy == cordw'(v_total - 1));
        sx_nxt    = line_end ? '0 : sx + cordw'(1);
        sy_nxt    = sy;
        if (line_end) begin
            sy_nxt = frame_end ? '0 : sy + cordw'(1);  // Advance one line
        end
    end

    // Decode the windows from the next position so outputs stay aligned
    always_comb begin
        sync_nxt.hsync = !((sx_nxt >= h_active + h_front)
                        && (sx_nxt < h_active + h_front + h_sync));  // Negative pulse
        sync_nxt.vsync = !((sy_nxt >= v_active + v_front)
                        && (sy_nxt < v_active + v_front + v_sync));
        sync_nxt.de    = (sx_nxt < h_active) && (sy_nxt < v_active);
        frame_nxt      = (sx_nxt == 0) && (sy_nxt == 0);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Park on the last pixel, first step out of reset lands on 0,0
            sx    <= cordw'(h_total - 1);
            sy    <= cordw'(v_total - 1);
            sync  <= sync_idle;
            frame <= 1'b0;
        end else begin
            sx    <= sx_nxt;
            sy    <= sy_nxt;
            sync  <= sync_nxt;
            frame <= frame_nxt;  // One cycle per frame
        end
    end

    // Line counter wraps before the total
    sx_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        sx < h_total);

endmodule

`default_nettype wire

//--- pattern/pattern_gen.sv
// ##################################################
// Test pattern generator: colour squares or a stitch
// pattern, selection taken on the frame pulse
// ##################################################

`timescale 1ns/10ps
`default_nettype none

module pattern_gen (
    input  wire                                       clk,
    input  wire                                       rst_n,
    input  wire logic signed [display_pkg::cordw-1:0] sx,
    input  wire logic signed [display_pkg::cordw-1:0] sy,
    input  wire display_pkg::sync_t                   sync_in,
    input  wire                                       frame,
    input  wire display_pkg::pattern_e                pattern_sel,  // Level, sampled per frame
    output display_pkg::rgb_t                         pix,
    output display_pkg::sync_t                        sync_out,     // Delayed to match pix
    output logic                                      frame_out
);

    import display_pkg::*;

    pattern_e       pat_q;    // Mode of the frame in progress
    pattern_e       pat_cur;
    logic [bpc-1:0] tile_x;   // Square index, also the stitch line index
    logic [bpc-1:0] tile_y;
    logic           on_col;
    logic           on_row;
    rgb_t           pix_nxt;

    always_comb begin
        pat_cur = frame ? pattern_sel : pat_q;  // Pixel 0,0 already uses the new mode
        tile_x  = sx[stitch_shift +: bpc];      // sx/16 mod 32
        tile_y  = sy[stitch_shift +: bpc];

        // Vertical stitch on a grid column, dashes toggle with the row
        on_col = (sx[stitch_shift-1:0] == '0) && (stitch_col_bits[tile_x] ^ tile_y[0]);
        // Horizontal stitch, same rule on the other axis
        on_row = (sy[stitch_shift-1:0] == '0) && (stitch_row_bits[tile_y] ^ tile_x[0]);

        case (pat_cur)
            pat_squares: begin
                pix_nxt.r = tile_x;
                pix_nxt.g = tile_y;
                pix_nxt.b = tile_x + tile_y;  // Wraps at 32
            end
            default: begin
                pix_nxt = (on_col || on_row) ? stitch_fg : stitch_bg;
            end
        endcase

        if (!sync_in.de) begin
            pix_nxt = '0;  // Black in blanking
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pat_q     <= pat_squares;
            sync_out  <= sync_idle;
            frame_out <= 1'b0;
        end else begin
            if (frame) begin
                pat_q <= pattern_sel;  // Hold for the rest of the frame
            end
            sync_out  <= sync_in;
            frame_out <= frame;
        end
    end

    always_ff @(posedge clk) begin
        pix <= pix_nxt;  // Colour register
    end

endmodule

`default_nettype wire

//--- encode/tmds_encoder.sv
// ##################################################
// TMDS 8b/10b encoder for one DVI channel, with
// running disparity and control symbols in blanking
// ##################################################

`timescale 1ns/10ps
`default_nettype none

module tmds_encoder (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire  [display_pkg::bpc_board-1:0]   din,   // Pixel data
    input  wire  [1:0]                          ctrl,  // {c1, c0}
    input  wire                                 de,
    output logic [display_pkg::sym_w-1:0]       sym
);

    import display_pkg::*;

    logic [3:0]        n1_d;      // Ones in din
    logic [3:0]        n1_q;      // Ones in q_m[7:0]
    logic              use_xnor;
    logic [8:0]        q_m;       // Transition minimised word
    logic signed [5:0] bal;       // Ones minus zeros of q_m[7:0]
    logic signed [5:0] disp_q;    // Running disparity
    logic signed [5:0] disp_nxt;
    logic [sym_w-1:0]  sym_nxt;
    logic [sym_w-1:0]  ctrl_sym;

    // Stage 1: XOR or XNOR chain, whichever gives fewer transitions
    always_comb begin
        n1_d = '0;
        for (int i = 0; i < 8; i++) begin
            n1_d = n1_d + 4'(din[i]);
        end
        use_xnor = (n1_d > 4'd4) || ((n1_d == 4'd4) && !din[0]);

        q_m[0] = din[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ din[i]) : (q_m[i-1] ^ din[i]);
        end
        q_m[8] = !use_xnor;  // 1 marks XOR

        n1_q = '0;
        for (int i = 0; i < 8; i++) begin
            n1_q = n1_q + 4'(q_m[i]);
        end
        bal = $signed({1'b0, n1_q, 1'b0}) - 6'sd8;  // 2*n1 - 8
    end

    // Stage 2: DC balance, invert the data bits when it pulls towards zero
    always_comb begin
        if ((disp_q == 0) || (bal == 0)) begin
            sym_nxt  = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            disp_nxt = q_m[8] ? disp_q + bal : disp_q - bal;
        end else if (((disp_q > 0) && (bal > 0)) || ((disp_q < 0) && (bal < 0))) begin
            sym_nxt  = {1'b1, q_m[8], ~q_m[7:0]};  // Inverted
            disp_nxt = disp_q + $signed({4'b0000, q_m[8], 1'b0}) - bal;
        end else begin
            sym_nxt  = {1'b0, q_m[8], q_m[7:0]};
            disp_nxt = disp_q - $signed({4'b0000, ~q_m[8], 1'b0}) + bal;
        end
    end

    always_comb begin
        case (ctrl)
            2'b00:   ctrl_sym = ctrl_00;
            2'b01:   ctrl_sym = ctrl_01;
            2'b10:   ctrl_sym = ctrl_10;
            default: ctrl_sym = ctrl_11;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || !de) begin
            sym    <= ctrl_sym;  // Blanking sends control
            disp_q <= '0;        // Balance restarts every active period
        end else begin
            sym    <= sym_nxt;
            disp_q <= disp_nxt;
        end
    end

    // Balance bound holds over any run of data symbols
    disp_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        (disp_q >= -10) && (disp_q <= 10));

endmodule

`default_nettype wire

//--- encode/dvi_encoder.sv
// ##################################################
// DVI encoder: widens 5-bit colour to 8 bits and
// TMDS-encodes blue, green and red
// ##################################################

`timescale 1ns/10ps
`default_nettype none

module dvi_encoder (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire display_pkg::rgb_t          pix,
    input  wire display_pkg::sync_t         sync,
    input  wire                             frame,      // Pulse from pattern stage
    output logic [display_pkg::sym_w-1:0]   sym_ch0,    // Blue, carries sync
    output logic [display_pkg::sym_w-1:0]   sym_ch1,    // Green
    output logic [display_pkg::sym_w-1:0]   sym_ch2,    // Red
    output logic                            frame_out   // Aligned with the symbols
);

    import display_pkg::*;

    logic [bpc_board-1:0] board_r;
    logic [bpc_board-1:0] board_g;
    logic [bpc_board-1:0] board_b;

    // Top bits repeated below so full scale maps to full scale
    assign board_r = {pix.r, pix.r[bpc-1 -: bpc_board-bpc]};
    assign board_g = {pix.g, pix.g[bpc-1 -: bpc_board-bpc]};
    assign board_b = {pix.b, pix.b[bpc-1 -: bpc_board-bpc]};

    tmds_encoder tmds_ch0 (
        .clk  (clk),
        .rst_n(rst_n),
        .din  (board_b),
        .ctrl ({sync.vsync, sync.hsync}),  // Sync rides on blue
        .de   (sync.de),
        .sym  (sym_ch0)
    );

    tmds_encoder tmds_ch1 (
        .clk  (clk),
        .rst_n(rst_n),
        .din  (board_g),
        .ctrl (2'b00),
        .de   (sync.de),
        .sym  (sym_ch1)
    );

    tmds_encoder tmds_ch2 (
        .clk  (clk),
        .rst_n(rst_n),
        .din  (board_r),
        .ctrl (2'b00),
        .de   (sync.de),
        .sym  (sym_ch2)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_out <= 1'b0;
        end else begin
            frame_out <= frame;  // Match the encoder register
        end
    end

endmodule

`default_nettype wire

//--- logic/display_top.sv
// ##################################################
// Display pipeline top: raster timing, test pattern
// and DVI encoding down to parallel TMDS symbols
// ##################################################

`timescale 1ns/10ps
`default_nettype none

module display_top (
    input  wire                            clk,          // 25.2 MHz pixel clock
    input  wire                            rst_n,
    input  wire display_pkg::pattern_e     pattern_sel,
    output logic [display_pkg::sym_w-1:0]  sym_ch0,
    output logic [display_pkg::sym_w-1:0]  sym_ch1,
    output logic [display_pkg::sym_w-1:0]  sym_ch2,
    output logic                           frame_out     // Frame pulse at the symbols
);

    import display_pkg::*;

    logic signed [cordw-1:0] sx;
    logic signed [cordw-1:0] sy;
    sync_t                   timing_sync;  // Aligned with the counters
    logic                    frame;
    rgb_t                    pix;
    sync_t                   pix_sync;     // One cycle later, with pix
    logic                    pix_frame;

    display_timing display_timing_inst (
        .clk  (clk),
        .rst_n(rst_n),
        .sx   (sx),
        .sy   (sy),
        .sync (timing_sync),
        .frame(frame)
    );

    pattern_gen pattern_gen_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .sx         (sx),
        .sy         (sy),
        .sync_in    (timing_sync),
        .frame      (frame),
        .pattern_sel(pattern_sel),
        .pix        (pix),
        .sync_out   (pix_sync),
        .frame_out  (pix_frame)
    );

    dvi_encoder dvi_encoder_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .pix      (pix),
        .sync     (pix_sync),
        .frame    (pix_frame),
        .sym_ch0  (sym_ch0),
        .sym_ch1  (sym_ch1),
        .sym_ch2  (sym_ch2),
        .frame_out(frame_out)
    );

    // Pixel 0,0 is active, so the frame pulse never lands on a control symbol
    frame_on_data: assert property (@(posedge clk) disable iff (!rst_n)
        frame_out |-> (sym_ch1 != ctrl_00));

endmodule

`default_nettype wire

//--- verif/tb_ref.svh
// ##################################################
// Testbench reference models for raster sync, pattern
// colour, colour widening and TMDS decode
// ##################################################

`ifndef TB_REF_SVH
`define TB_REF_SVH

// Expected sync and data enable at a raster position
function automatic sync_t raster_sync(input int x, input int y);
    sync_t s;
    s.hsync = !((x >= h_active + h_front) && (x < h_active + h_front + h_sync));
    s.vsync = !((y >= v_active + v_front) && (y < v_active + v_front + v_sync));
    s.de    = (x < h_active) && (y < v_active);  // Active area at top-left
    return s;
endfunction

// Colour of an active pixel in the given mode
function automatic rgb_t pattern_colour(input pattern_e mode, input int x, input int y);
    rgb_t c;
    int   col;
    int   row;
    logic on_col;
    logic on_row;
    col = (x / stitch_size) % 32;  // Square index wraps like a 5-bit channel
    row = (y / stitch_size) % 32;
    if (mode == pat_squares) begin
        c.r = 5'(col);
        c.g = 5'(row);
        c.b = 5'((col + row) % 32);
    end else begin
        // Dashes on a grid line alternate with the crossing index
        on_col = ((x % stitch_size) == 0) && ((stitch_col_bits[col] ^ row[0]) == 1'b1);
        on_row = ((y % stitch_size) == 0) && ((stitch_row_bits[row] ^ col[0]) == 1'b1);
        c      = (on_col || on_row) ? stitch_fg : stitch_bg;
    end
    return c;
endfunction

// Five bits to eight with the top bits copied into the low end
function automatic logic [7:0] widen_channel(input logic [4:0] c);
    return {c, 3'b000} | 8'(c >> 2);
endfunction

// DVI 1.0 decode of a data symbol
function automatic logic [7:0] tmds_decode(input logic [9:0] s);
    logic [7:0] q;
    logic [7:0] d;
    q    = s[9] ? ~s[7:0] : s[7:0];  // Undo the DC inversion
    d[0] = q[0];
    for (int i = 1; i < 8; i++) begin
        d[i] = s[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);  // Bit 8 set means XOR
    end
    return d;
endfunction

// Ones minus zeros over all ten bits
function automatic int symbol_balance(input logic [9:0] s);
    int ones;
    ones = 0;
    for (int i = 0; i < 10; i++) begin
        ones += int'(s[i]);
    end
    return 2 * ones - 10;
endfunction

// Control symbol table from the DVI spec indexed by {c1, c0}
function automatic logic [9:0] control_code(input logic [1:0] c);
    case (c)
        2'b00:   return 10'b1101010100;
        2'b01:   return 10'b0010101011;
        2'b10:   return 10'b0101010100;
        default: return 10'b1010101011;
    endcase
endfunction

`endif

//--- verif/tb_display_top.sv
// ##################################################
// Testbench for the display pipeline that decodes
// the TMDS symbols and checks them against the reference
// ##################################################

`timescale 1ns/10ps
`default_nettype none

module tb_display_top;

    import display_pkg::*;

    `include "tb_ref.svh"

    localparam int run_frames     = 3;
    localparam int timeout_cycles = run_frames * frame_cycles + 100;

    logic             clk;
    logic             rst_n;
    pattern_e         pattern_sel;
    logic [sym_w-1:0] sym_ch0;
    logic [sym_w-1:0] sym_ch1;
    logic [sym_w-1:0] sym_ch2;
    logic             frame_out;

    int          run_cyc;      // Clocks seen with rst_n high
    int          all_cyc;      // Every clock for the timeout
    int          errors;
    int          checks;
    int          shown;        // Error lines printed so far
    int          pulses;       // frame_out pulses seen
    int          disp [3];     // Running disparity per channel
    logic        checks_done;
    logic        timed_out;
    logic [31:0] lcg_state;

    initial clk = 1'b0;
    always #2 clk = ~clk;  // 4 ns period

    display_top display_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .pattern_sel(pattern_sel),
        .sym_ch0    (sym_ch0),
        .sym_ch1    (sym_ch1),
        .sym_ch2    (sym_ch2),
        .frame_out  (frame_out)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Mode latched at each frame pulse alternates squares and stitch
    function automatic pattern_e frame_mode(input int f);
        return (f % 2 == 1) ? pat_stitch : pat_squares;
    endfunction

    task automatic check_value(input string test, input string item, input int x,
                               input int y, input int exp, input int got);
        checks++;
        assert (exp == got) else begin
            errors++;
            if (shown < 40) begin
                $display("** Error %s %s at (%0d, %0d): expected %0h, actual %0h",
                         test, item, x, y, exp, got);
                shown++;
            end
        end
    endtask

    task automatic track_balance(input int ch, input logic [sym_w-1:0] s,
                                 input int x, input int y);
        disp[ch] += symbol_balance(s);
        checks++;
        assert ((disp[ch] >= -10) && (disp[ch] <= 10)) else begin
            errors++;
            if (shown < 40) begin
                $display("Channel %0d running disparity left the -10..10 band at (%0d, %0d): %0d",
                         ch, x, y, disp[ch]);
                shown++;
            end
        end
    endtask

    always @(posedge clk) begin
        all_cyc <= all_cyc + 1;
        if (rst_n) begin
            run_cyc <= run_cyc + 1;  // 1 means the counters hold 0,0
        end
        if (all_cyc + 1 >= timeout_cycles) begin
            timed_out <= 1'b1;
        end
    end

    // Reset then one mode change at a random point inside each frame
    initial begin
        int target;
        rst_n       = 1'b0;
        pattern_sel = pat_squares;
        run_cyc     = 0;
        all_cyc     = 0;
        errors      = 0;
        checks      = 0;
        shown       = 0;
        pulses      = 0;
        disp        = '{0, 0, 0};
        checks_done = 1'b0;
        timed_out   = 1'b0;
        lcg_state   = 32'h5fae2ccb;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int f = 0; f < run_frames; f++) begin
            lcg_state = lcg_next(lcg_state);
            // Stay well clear of both frame pulses
            target = 1 + f * frame_cycles + frame_cycles / 8
                   + int'(lcg_state >> 12) % (frame_cycles * 3 / 4);
            while (run_cyc < target) @(posedge clk);
            pattern_sel <= (f % 2 == 0) ? pat_stitch : pat_squares;
        end
    end

    // Compare at the falling edge where outputs have settled
    always @(negedge clk) begin : compare
        int    idx;
        int    x;
        int    y;
        sync_t es;
        rgb_t  ec;
        string tname;
        if ((all_cyc >= 2) && !checks_done) begin
            if (run_cyc < 1 + pix_lat) begin
                check_value("reset", "ch0", -1, -1, int'(ctrl_11), int'(sym_ch0));
                check_value("reset", "ch1", -1, -1, int'(ctrl_00), int'(sym_ch1));
                check_value("reset", "ch2", -1, -1, int'(ctrl_00), int'(sym_ch2));
                check_value("reset", "frame_out", -1, -1, 0, int'(frame_out));
            end else begin
                idx = run_cyc - 1 - pix_lat;  // Pixel carried by these symbols
                x   = idx % h_total;
                y   = (idx / h_total) % v_total;
                es  = raster_sync(x, y);
                check_value("frame_out", "pulse", x, y, int'(x == 0 && y == 0),
                            int'(frame_out));
                if (frame_out) begin
                    pulses++;
                end
                if (!es.de) begin
                    check_value("blank", "ch0", x, y, int'(control_code({es.vsync, es.hsync})),
                                int'(sym_ch0));
                    check_value("blank", "ch1", x, y, int'(ctrl_00), int'(sym_ch1));
                    check_value("blank", "ch2", x, y, int'(ctrl_00), int'(sym_ch2));
                    disp = '{0, 0, 0};  // Balance restarts with each blanking period
                end else begin
                    ec    = pattern_colour(frame_mode(idx / frame_cycles), x, y);
                    tname = (frame_mode(idx / frame_cycles) == pat_squares) ? "squares" : "stitch";
                    check_value(tname, "blue", x, y, int'(widen_channel(ec.b)),
                                int'(tmds_decode(sym_ch0)));
                    check_value(tname, "green", x, y, int'(widen_channel(ec.g)),
                                int'(tmds_decode(sym_ch1)));
                    check_value(tname, "red", x, y, int'(widen_channel(ec.r)),
                                int'(tmds_decode(sym_ch2)));
                    track_balance(0, sym_ch0, x, y);
                    track_balance(1, sym_ch1, x, y);
                    track_balance(2, sym_ch2, x, y);
                end
                if (idx == run_frames * frame_cycles - 1) begin
                    checks_done <= 1'b1;
                end
            end
        end
    end

    initial begin
        wait (checks_done || timed_out);
        if (!checks_done) begin
            errors++;
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
        end else begin
            check_value("frame_out", "count", -1, -1, run_frames, pulses);
        end
        $display("Checks: %0d, errors: %0d, frame pulses: %0d", checks, errors, pulses);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verif
common/display_pkg.sv
logic/display_timing.sv
pattern/pattern_gen.sv
encode/tmds_encoder.sv
encode/dvi_encoder.sv
logic/display_top.sv
verif/tb_display_top.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_display_top
FLIST     := flist.f

MDIR      := obj_dir
SIM       := $(MDIR)/V$(TOP)
SRCS      := $(filter-out +%,$(shell cat $(FLIST))) verif/tb_ref.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'Test OK'

clean:
	rm -rf $(MDIR)
